/* include/cast_defines.svh */
// Width constants for the binary32 <-> int32 conversion unit
// Only binary32 and 32-bit integers are supported; changing these alone
// does not retarget the datapath to other formats
`ifndef CAST_DEFINES_SVH
`define CAST_DEFINES_SVH

// Integer side
`define CAST_INT_W   32  // Integer operand and result width

// binary32 fields
`define CAST_EXP_W   8   // Exponent field
`define CAST_MAN_W   23  // Fraction field, hidden bit excluded
`define CAST_BIAS    127 // Exponent bias

// Internal signed exponent, must hold -149 .. 135
`define CAST_IEXP_W  10

// Opaque tag carried next to every item
`define CAST_TAG_W   8

`endif

/* hw/cast_pkg.sv */
// Types shared by the conversion pipeline
// OF and UF exist in the status word but the datapath never raises them
`include "cast_defines.svh"

package cast_pkg;

  // Rounding modes, encoding matches the RISC-V frm field
  typedef enum logic [2:0] {
    RNE = 3'd0, // Nearest, ties to even
    RTZ = 3'd1, // Toward zero
    RDN = 3'd2, // Toward -inf
    RUP = 3'd3, // Toward +inf
    RMM = 3'd4  // Nearest, ties away from zero
  } roundmode_e;

  typedef enum logic {
    I2F = 1'b0, // Integer to float
    F2I = 1'b1  // Float to integer
  } operation_e;

  typedef struct packed {
    logic nv; // Invalid
    logic of; // Overflow, always 0 here
    logic uf; // Underflow, always 0 here
    logic nx; // Inexact
  } status_t;

  // Classification of a binary32 input
  typedef struct packed {
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_subnormal;
  } fp_class_t;

  // ------------------------------------------------------------
  // Pipeline payloads
  // ------------------------------------------------------------
  typedef struct packed {
    operation_e                      op;
    logic                            op_mod;       // 1: unsigned integer
    roundmode_e                      rnd_mode;
    logic                            sign;
    logic signed [`CAST_IEXP_W-1:0]  exp;          // Unbiased
    logic        [`CAST_INT_W-1:0]   mant;         // Leading one at the MSB
    logic                            mant_is_zero;
    fp_class_t                       cls;
    logic        [`CAST_TAG_W-1:0]   tag;
  } norm_t;

  typedef struct packed {
    logic [`CAST_INT_W-1:0] result;
    status_t                status;
    logic [`CAST_TAG_W-1:0] tag;
  } res_t;

endpackage

/* hw/cast_align_if.sv */
// Aligned mantissa and pre-rounding info, aligner to rounder
// Both the FP and the integer view are always driven
`include "cast_defines.svh"

interface cast_align_if;

  logic [`CAST_MAN_W-1:0] final_mant;      // binary32 fraction, hidden bit dropped
  logic [`CAST_INT_W-1:0] final_int;       // Integer magnitude before rounding
  logic [1:0]             fp_rs;           // Round, sticky for the FP result
  logic [1:0]             int_rs;          // Round, sticky for the integer result
  logic                   of_before_round; // F2I exponent beyond integer range

  // Aligner side
  modport if_align (
    output final_mant, final_int, fp_rs, int_rs, of_before_round
  );

  // Rounder side
  modport if_round (
    input final_mant, final_int, fp_rs, int_rs, of_before_round
  );

endinterface

/* hw/cast_pipe_stage.sv */
// Single valid/ready register slice
// Ready passes combinationally from out_ready_i, so chained slices form one
// long ready path. Payload has no reset, only the valid bit does
module cast_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,    // Drops the held item at the next edge
  // Upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // Downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;
  logic     load; // Item accepted this cycle

  // Can take a new item if the held one leaves or there is none
  assign in_ready_o = out_ready_i | ~valid_q;
  assign load       = in_ready_o & in_valid_i;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i; // Bubble in when nothing offered
    end
  end

  // Payload only moves on a real transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

/* hw/cast_normalize.sv */
// Input decode and normalization, purely combinational
// Float inputs are read as binary32; integer inputs as 32-bit, signed when
// op_mod_i is 0. A zero mantissa is flagged, its exponent is meaningless
`include "cast_defines.svh"

module cast_normalize (
  input  logic [`CAST_INT_W-1:0] operand_i,
  input  cast_pkg::operation_e   op_i,
  input  logic                   op_mod_i,   // 1: unsigned integer
  input  cast_pkg::roundmode_e   rnd_mode_i,
  input  logic [`CAST_TAG_W-1:0] tag_i,
  output cast_pkg::norm_t        norm_o
);

  import cast_pkg::*;

  localparam int W      = `CAST_INT_W;
  localparam int EXP_W  = `CAST_EXP_W;
  localparam int MAN_W  = `CAST_MAN_W;
  localparam int IEXP_W = `CAST_IEXP_W;
  localparam int LZC_W  = $clog2(`CAST_INT_W);
  localparam int COMP   = W - 1 - MAN_W; // FP mantissa sits right-aligned, 8 bits short

  // ------------------------------------------------------------
  // Float classification
  // ------------------------------------------------------------
  logic             fp_sign;
  logic [EXP_W-1:0] fp_exp;
  logic [MAN_W-1:0] fp_frac;
  logic             exp_zero, exp_ones, frac_zero;
  fp_class_t        cls;

  assign fp_sign = operand_i[W-1];
  assign fp_exp  = operand_i[MAN_W +: EXP_W];
  assign fp_frac = operand_i[MAN_W-1:0];

  assign exp_zero  = (fp_exp == '0);
  assign exp_ones  = (fp_exp == '1);
  assign frac_zero = (fp_frac == '0);

  assign cls.is_zero       = exp_zero & frac_zero;
  assign cls.is_subnormal  = exp_zero & ~frac_zero;
  assign cls.is_inf        = exp_ones & frac_zero;
  assign cls.is_nan        = exp_ones & ~frac_zero;
  assign cls.is_signalling = cls.is_nan & ~fp_frac[MAN_W-1]; // Quiet bit clear

  // ------------------------------------------------------------
  // Integer magnitude
  // ------------------------------------------------------------
  logic         int_sign;
  logic [W-1:0] int_mag;

  assign int_sign = operand_i[W-1] & ~op_mod_i; // Unsigned ints are never negative
  assign int_mag  = int_sign ? -operand_i : operand_i;

  // Mantissa to normalize, FP hidden bit is 0 for subnormals
  logic [W-1:0] enc_mant;

  assign enc_mant = (op_i == I2F) ? int_mag
                                  : {{COMP{1'b0}}, ~exp_zero, fp_frac};

  // Leading-zero count, highest set bit wins
  logic [LZC_W-1:0] lz_cnt;

  always_comb begin
    lz_cnt = '0;
    for (int i = 0; i < W; i++) begin
      if (enc_mant[i]) lz_cnt = LZC_W'(W - 1 - i);
    end
  end

  // ------------------------------------------------------------
  // Exponent and output
  // ------------------------------------------------------------
  logic [IEXP_W-1:0] lz_ext, int_exp, fp_exp_unb;

  assign lz_ext     = IEXP_W'(lz_cnt);
  assign int_exp    = IEXP_W'(W - 1) - lz_ext;
  // Subnormals use an exponent field of 1
  assign fp_exp_unb = IEXP_W'(fp_exp) + IEXP_W'(cls.is_subnormal) - IEXP_W'(`CAST_BIAS)
                      - lz_ext + IEXP_W'(COMP);

  assign norm_o.op           = op_i;
  assign norm_o.op_mod       = op_mod_i;
  assign norm_o.rnd_mode     = rnd_mode_i;
  assign norm_o.sign         = (op_i == I2F) ? int_sign : fp_sign;
  assign norm_o.exp          = (op_i == I2F) ? int_exp : fp_exp_unb;
  assign norm_o.mant         = enc_mant << lz_cnt;   // MSB now 1 unless zero
  assign norm_o.mant_is_zero = ~|enc_mant;
  assign norm_o.cls          = cls;
  assign norm_o.tag          = tag_i;

endmodule

/* hw/cast_align.sv */
// Moves the normalized mantissa into result position, combinational
// F2I shifts right by 31 - exp; I2F keeps the top 24 bits as significand.
// Exponents below -1 push the whole mantissa into sticky
`include "cast_defines.svh"

module cast_align (
  input  cast_pkg::norm_t   norm_i,
  cast_align_if.if_align    al
);

  import cast_pkg::*;

  localparam int W      = `CAST_INT_W;
  localparam int MAN_W  = `CAST_MAN_W;
  localparam int IEXP_W = `CAST_IEXP_W;
  localparam int SH_W   = $clog2(W + 2); // Shift reaches W+1

  logic signed [IEXP_W-1:0] exp_s;
  logic signed [IEXP_W-1:0] of_lim;   // First exponent out of integer range
  logic        [SH_W-1:0]   shamt;
  logic        [2*W:0]      preshift; // Mantissa, round slot, sticky field
  logic        [2*W:0]      shifted;
  logic                     of_d;

  assign exp_s  = norm_i.exp;
  // Unsigned range is one bit wider
  assign of_lim = norm_i.op_mod ? IEXP_W'(W) : IEXP_W'(W - 1);

  // ------------------------------------------------------------
  // Integer alignment
  // ------------------------------------------------------------
  always_comb begin
    shamt = SH_W'(IEXP_W'(W - 1) - exp_s);
    of_d  = 1'b0;
    if (exp_s >= of_lim) begin
      shamt = '0;                // Result is saturated anyway
      of_d  = 1'b1;
    end else if (exp_s < -1) begin
      shamt = SH_W'(W + 1);      // Below 0.5, everything is sticky
    end
  end

  assign preshift = {norm_i.mant, {(W + 1){1'b0}}};
  assign shifted  = preshift >> shamt;

  assign al.final_int       = shifted[2*W -: W];
  assign al.int_rs          = {shifted[W], |shifted[W-1:0]};
  assign al.of_before_round = of_d & (norm_i.op == F2I); // I2F never overflows

  // ------------------------------------------------------------
  // binary32 alignment
  // ------------------------------------------------------------
  // Hidden bit at W-1 is dropped, fraction follows
  assign al.final_mant = norm_i.mant[W-2 -: MAN_W];
  assign al.fp_rs      = {norm_i.mant[W-2-MAN_W], |norm_i.mant[W-3-MAN_W:0]};

endmodule

/* hw/cast_round.sv */
// Rounding, special cases and status, combinational
// Integer overflow saturates per sign and op_mod with NV alone;
// OF and UF are never raised since binary32 covers every int32 value
`include "cast_defines.svh"

module cast_round (
  input  cast_pkg::norm_t   norm_i,
  cast_align_if.if_round    al,
  output cast_pkg::res_t    res_o
);

  import cast_pkg::*;

  localparam int W     = `CAST_INT_W;
  localparam int EXP_W = `CAST_EXP_W;

  logic             f2i;
  logic [EXP_W-1:0] biased_exp;
  logic [W-1:0]     pre_abs;     // Magnitude before rounding
  logic [1:0]       rs;          // Round, sticky
  logic             round_up;
  logic             carry;
  logic [W-1:0]     rounded_abs;

  assign f2i        = (norm_i.op == F2I);
  assign biased_exp = EXP_W'(norm_i.exp + `CAST_BIAS);
  // FP form is exponent over fraction, a fraction carry bumps the exponent
  assign pre_abs    = f2i ? al.final_int : W'({biased_exp, al.final_mant});
  assign rs         = f2i ? al.int_rs : al.fp_rs;

  // ------------------------------------------------------------
  // Rounding decision
  // ------------------------------------------------------------
  always_comb begin
    unique case (norm_i.rnd_mode)
      RNE:     round_up = rs[1] & (rs[0] | pre_abs[0]); // Tie goes to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = norm_i.sign & (|rs);
      RUP:     round_up = ~norm_i.sign & (|rs);
      RMM:     round_up = rs[1];
      default: round_up = 1'b0;                         // Reserved codes
    endcase
  end

  assign {carry, rounded_abs} = {1'b0, pre_abs} + (W + 1)'(round_up);

  // I2F result, integer zero gives +0
  logic [W-1:0] fp_result;
  status_t      fp_status;

  assign fp_result = norm_i.mant_is_zero ? '0 : {norm_i.sign, rounded_abs[W-2:0]};
  assign fp_status = '{nx: |al.fp_rs, default: 1'b0};

  // ------------------------------------------------------------
  // F2I result and saturation
  // ------------------------------------------------------------
  logic [W-1:0] rounded_int;     // Two's complement
  logic         rounded_int_zero;
  logic         of_after;        // Rounding carried out of range
  logic         is_special;
  logic [W-1:0] special_res;
  status_t      int_status;

  assign rounded_int      = norm_i.sign ? -rounded_abs : rounded_abs;
  assign rounded_int_zero = (rounded_int == '0);
  // Signed: above 2^31-1, or above 2^31 when negative
  assign of_after = carry | (~norm_i.op_mod & rounded_abs[W-1] &
                             ~(norm_i.sign & ~|rounded_abs[W-2:0]));

  assign is_special = norm_i.cls.is_nan | norm_i.cls.is_inf | al.of_before_round |
                      of_after | (norm_i.sign & norm_i.op_mod & ~rounded_int_zero);

  always_comb begin
    special_res = {norm_i.op_mod, {(W - 1){1'b1}}}; // Positive max
    if (norm_i.sign && !norm_i.cls.is_nan) begin
      special_res = ~special_res;                   // Negative max, or 0 if unsigned
    end
  end

  assign int_status = is_special ? '{nv: 1'b1, default: 1'b0}
                                 : '{nx: |al.int_rs, default: 1'b0};

  // Output selection
  assign res_o.result = f2i ? (is_special ? special_res : rounded_int) : fp_result;
  assign res_o.status = f2i ? int_status : fp_status;
  assign res_o.tag    = norm_i.tag;

endmodule

/* hw/cast_top.sv */
// binary32 <-> int32 conversion unit, two register stages
// Latency 2 cycles at full throughput; ready is combinational from
// out_ready_i to in_ready_o. flush_i drops everything in flight
`include "cast_defines.svh"

module cast_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Request
  input  logic [`CAST_INT_W-1:0] operand_i,
  input  cast_pkg::operation_e   op_i,
  input  logic                   op_mod_i,    // 1: unsigned integer
  input  cast_pkg::roundmode_e   rnd_mode_i,
  input  logic [`CAST_TAG_W-1:0] tag_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  logic                   flush_i,
  // Response
  output logic [`CAST_INT_W-1:0] result_o,
  output cast_pkg::status_t      status_o,
  output logic [`CAST_TAG_W-1:0] tag_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o       // Any stage holds an item
);

  import cast_pkg::*;

  norm_t norm_d, norm_q;
  res_t  res_d, res_q;
  logic  norm_valid;
  logic  out_stage_ready; // Downstream ready seen by the first stage

  cast_align_if al_if ();

  // ------------------------------------------------------------
  // Stage 1: decode and normalize
  // ------------------------------------------------------------
  cast_normalize i_normalize (
    .operand_i  (operand_i),
    .op_i       (op_i),
    .op_mod_i   (op_mod_i),
    .rnd_mode_i (rnd_mode_i),
    .tag_i      (tag_i),
    .norm_o     (norm_d)
  );

  cast_pipe_stage #(.payload_t(norm_t)) s_norm (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (norm_d),
    .out_valid_o (norm_valid),
    .out_ready_i (out_stage_ready),
    .out_data_o  (norm_q)
  );

  // ------------------------------------------------------------
  // Stage 2: align, round, output register
  // ------------------------------------------------------------
  cast_align i_align (
    .norm_i (norm_q),
    .al     (al_if.if_align)
  );

  cast_round i_round (
    .norm_i (norm_q),
    .al     (al_if.if_round),
    .res_o  (res_d)
  );

  cast_pipe_stage #(.payload_t(res_t)) s_out (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (norm_valid),
    .in_ready_o  (out_stage_ready),
    .in_data_i   (res_d),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (res_q)
  );

  assign result_o = res_q.result;
  assign status_o = res_q.status;
  assign tag_o    = res_q.tag;
  assign busy_o   = norm_valid | out_valid_o;

endmodule

/* sim/tb_clk_gen.sv */
// Free-running testbench clock, period 4, starts low
module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

endmodule

/* sim/cast_props.sv */
// Handshake properties of cast_top, bound to every instance
// Flush may drop a stalled item, so the hold rule skips flush cycles
module cast_props (
  input logic        clk_i,
  input logic        rst_i,
  input logic        flush_i,
  input logic        in_ready_o,
  input logic        out_valid_o,
  input logic        out_ready_i,
  input logic        busy_o,
  input logic [31:0] result_o,
  input logic [3:0]  status_o,
  input logic [7:0]  tag_o
);

  // Valid is cleared once a reset edge has been seen
  a_rst_valid: assert property (@(posedge clk_i) $past(rst_i) |-> !out_valid_o)
    else $error("out_valid_o high during reset");

  // Stalled output keeps its item
  a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o))
    else $error("output changed while stalled");

  a_idle_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    !busy_o |-> in_ready_o)
    else $error("in_ready_o low while idle");

endmodule

bind cast_top cast_props u_props (.*);

/* sim/tb_cast.sv */
// Directed tests for the conversion unit, inputs change on falling edges
// Expected values come from bit-level reference models below
module tb_cast;

  import cast_pkg::*;

  logic        clk_i, rst_i, flush_i, in_valid_i, in_ready_o, op_mod_i;
  logic        out_valid_o, out_ready_i, busy_o;
  logic [31:0] operand_i, result_o;
  logic [7:0]  tag_i, tag_o;
  operation_e  op_i;
  roundmode_e  rnd_mode_i;
  status_t     status_o;

  integer      seed = 32'hf65a;
  string       cur_test;
  logic [7:0]  tag_cnt;
  logic [31:0] q_res[$];    // Expected results in order
  logic [3:0]  q_stat[$];
  logic [7:0]  q_tag[$];
  localparam int TMO = 50;  // Cycles per wait

  tb_clk_gen u_clk (.clk_o(clk_i));

  cast_top DUT (.*);

  // ------------------------------------------------------------
  // Reference models
  // ------------------------------------------------------------
  function automatic logic rnd_up(roundmode_e m, logic s, logic lsb, logic r, logic sk);
    case (m)
      RNE:     return r & (sk | lsb);
      RDN:     return s & (r | sk);
      RUP:     return ~s & (r | sk);
      RMM:     return r;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] i2f_ref(logic [31:0] x, logic uns, roundmode_e m,
                                          output logic [3:0] st);
    logic        s;
    logic [63:0] mag, sig, rem;
    int          p, sh;
    logic [7:0]  e;
    st  = 4'b0;
    s   = x[31] & ~uns;
    mag = {32'd0, s ? -x : x};
    if (mag == 0) return 32'd0;
    p = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) p = i;
    end
    sh  = (p > 23) ? p - 23 : 0;
    sig = (p > 23) ? mag >> sh : mag << (23 - p);
    rem = mag & ((64'd1 << sh) - 1);
    e   = 8'(p + 127);
    if (sh > 0) begin
      sig = sig + 64'(rnd_up(m, s, sig[0], rem[sh-1], (rem & ((64'd1 << (sh - 1)) - 1)) != 0));
      if (sig[24]) begin
        sig = sig >> 1; // Carry into the exponent
        e   = e + 8'd1;
      end
      st[0] = (rem != 0);
    end
    return {s, e, sig[22:0]};
  endfunction

  function automatic logic [31:0] sat_val(logic s, logic uns);
    if (uns) return s ? 32'h0 : 32'hffff_ffff;
    return s ? 32'h8000_0000 : 32'h7fff_ffff;
  endfunction

  function automatic logic [31:0] f2i_ref(logic [31:0] f, logic uns, roundmode_e m,
                                          output logic [3:0] st);
    logic        s, r, sk, spec;
    int          be, e, sh;
    logic [63:0] man, ab;
    s  = f[31];
    be = int'(f[30:23]);
    st = 4'b1000;
    r  = 1'b0;
    sk = 1'b0;
    if (be == 255) return (f[22:0] != 0) ? sat_val(1'b0, uns) : sat_val(s, uns);
    // Exponent at 31, or 32 when unsigned, is out of range before rounding
    if (be - 127 >= 31 + int'(uns)) return sat_val(s, uns);
    man = {40'd0, be != 0, f[22:0]};
    e   = ((be == 0) ? 1 : be) - 150;
    if (e >= 0) begin
      ab = man << e;
    end else begin
      sh = -e;
      if (sh >= 40) begin
        ab = 64'd0;
        sk = (man != 0);
      end else begin
        ab = man >> sh;
        r  = man[sh-1];
        sk = (man & ((64'd1 << (sh - 1)) - 1)) != 0;
      end
    end
    ab = ab + 64'(rnd_up(m, s, ab[0], r, sk));
    if (uns) spec = s ? (ab != 0) : (ab > 64'hffff_ffff);
    else     spec = s ? (ab > 64'h8000_0000) : (ab > 64'h7fff_ffff);
    if (spec) return sat_val(s, uns);
    st = {3'b000, r | sk};
    return s ? -ab[31:0] : ab[31:0];
  endfunction

  // ------------------------------------------------------------
  // Drivers and checker
  // ------------------------------------------------------------
  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  // Offer one item, hold until accepted, queue its expected response
  task automatic send(operation_e op, logic uns, roundmode_e m, logic [31:0] x);
    logic [3:0] st;
    int         n;
    q_res.push_back(op == I2F ? i2f_ref(x, uns, m, st) : f2i_ref(x, uns, m, st));
    q_stat.push_back(st);
    q_tag.push_back(tag_cnt);
    op_i       = op;
    op_mod_i   = uns;
    rnd_mode_i = m;
    operand_i  = x;
    tag_i      = tag_cnt;
    in_valid_i = 1'b1;
    n = 0;
    while (!in_ready_o) begin
      @(negedge clk_i);
      n++;
      if (n > TMO) fail_run($sformatf("%s: in_ready_o never rose", cur_test));
    end
    @(negedge clk_i); // Taken at the rising edge in between
    in_valid_i = 1'b0;
    tag_cnt    = tag_cnt + 8'd1;
  endtask

  task automatic recv();
    logic [31:0] er;
    logic [3:0]  es;
    logic [7:0]  et;
    int          n;
    n = 0;
    while (!out_valid_o) begin
      @(negedge clk_i);
      n++;
      if (n > TMO) fail_run($sformatf("%s: out_valid_o never rose", cur_test));
    end
    er = q_res.pop_front();
    es = q_stat.pop_front();
    et = q_tag.pop_front();
    assert (result_o == er && status_o == es && tag_o == et) else
      fail_run($sformatf("mismatch %s expected %h/%b/%h actual %h/%b/%h",
                         cur_test, er, es, et, result_o, status_o, tag_o));
    @(negedge clk_i);
  endtask

  task automatic send_and_check(operation_e op, logic uns, roundmode_e m, logic [31:0] x);
    send(op, uns, m, x);
    recv();
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_i2f_exact();
    logic [31:0] vals[6] = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'd1000, 32'd7};
    cur_test = "i2f_exact";
    foreach (vals[i]) begin
      send_and_check(I2F, 1'b0, RNE, vals[i]);
      if (i != 3) send_and_check(I2F, 1'b1, RNE, vals[i] & 32'h00ff_ffff);
    end
  endtask

  task automatic test_i2f_round();
    logic [31:0] x;
    cur_test = "i2f_round";
    for (int i = 0; i < 8; i++) begin
      x = $random(seed) | 32'h0100_0000;
      for (int k = 0; k < 5; k++) begin
        send_and_check(I2F, 1'b0, roundmode_e'(k), x);
        send_and_check(I2F, 1'b1, roundmode_e'(k), x);
      end
    end
  endtask

  task automatic test_f2i_range();
    logic [31:0] fixed[5] = '{32'h4020_0000, 32'hc020_0000, 32'h3f00_0000,
                              32'hbf00_0000, 32'hbe99_999a};
    logic [31:0] u, x;
    cur_test = "f2i_range";
    for (int k = 0; k < 5; k++) begin
      foreach (fixed[i]) begin
        send_and_check(F2I, 1'b0, roundmode_e'(k), fixed[i]);
        send_and_check(F2I, 1'b1, roundmode_e'(k), fixed[i]);
      end
      for (int i = 0; i < 6; i++) begin
        u = $random(seed);
        // Exponent 2^-7 .. 2^29, random fraction
        x = {u[31], 8'(120 + (u[30:8] % 37)), 23'($random(seed))};
        send_and_check(F2I, u[0], roundmode_e'(k), x);
      end
    end
  endtask

  task automatic test_f2i_special();
    logic [31:0] vals[7] = '{32'h7fc0_0000, 32'h7f80_0001, 32'h7f80_0000,
                             32'hff80_0000, 32'h4f00_0000, 32'hcf00_0000,
                             32'hc000_0000};
    cur_test = "f2i_special";
    foreach (vals[i]) begin
      send_and_check(F2I, 1'b0, RNE, vals[i]);
      send_and_check(F2I, 1'b1, RTZ, vals[i]);
    end
    send_and_check(F2I, 1'b1, RNE, 32'h4f80_0000); // 2^32
  endtask

  task automatic test_backpressure();
    int n;
    cur_test    = "backpressure";
    out_ready_i = 1'b0;
    n = 0;
    // Fill until the unit stops taking items
    while (in_ready_o) begin
      if (n[0]) send(F2I, 1'b0, RUP, 32'h4020_0000);
      else      send(I2F, 1'b0, RNE, 32'(n + 5));
      n++;
      if (n > TMO) fail_run("backpressure: in_ready_o never fell");
    end
    assert (n == 2) else
      fail_run($sformatf("mismatch %s expected %0d actual %0d", cur_test, 2, n));
    repeat (3) @(negedge clk_i); // Keep the stall on
    assert (!in_ready_o && out_valid_o) else
      fail_run("backpressure: stalled pipeline did not hold its items");
    out_ready_i = 1'b1;
    for (int i = 0; i < n; i++) begin
      recv();
    end
    send(I2F, 1'b1, RTZ, 32'hffff_ffff);
    recv();
  endtask

  task automatic test_flush();
    cur_test    = "flush";
    out_ready_i = 1'b0;
    send(I2F, 1'b0, RNE, 32'd9);
    send(I2F, 1'b0, RNE, 32'd10);
    assert (busy_o) else fail_run("flush: busy_o low with items in flight");
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    assert (!busy_o && !out_valid_o) else fail_run("flush: items still in flight");
    q_res.delete();
    q_stat.delete();
    q_tag.delete();
    out_ready_i = 1'b1;
    send_and_check(F2I, 1'b0, RDN, 32'hc020_0000);
  endtask

  initial begin
    rst_i       = 1'b1;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    operand_i   = '0;
    op_i        = I2F;
    op_mod_i    = 1'b0;
    rnd_mode_i  = RNE;
    tag_i       = '0;
    tag_cnt     = 8'd0;
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    test_i2f_exact();
    test_i2f_round();
    test_f2i_range();
    test_f2i_special();
    test_backpressure();
    test_flush();
    $display("TEST PASS");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
hw/cast_pkg.sv
hw/cast_align_if.sv
hw/cast_pipe_stage.sv
hw/cast_normalize.sv
hw/cast_align.sv
hw/cast_round.sv
hw/cast_top.sv
sim/tb_clk_gen.sv
sim/cast_props.sv
sim/tb_cast.sv

/* Makefile */
SIM      = verilator
TOP      = tb_cast
FILELIST = all.f
FLAGS    = --binary --timing --assert -Wall -Wno-fatal
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
